// ==== hw/classSelect.sv ====
`include "classifier_cfg.svh"

module classSelect (
	input logic clk,
	input logic reset,
	input classifierPkg::scoreVec scores,
	output classifierPkg::classIdx classOut,
	output logic [`ACT_WIDTH-1:0] bestScore
);

	import classifierPkg::*;

	classIdx bestIdx;
	logic [`ACT_WIDTH-1:0] bestVal;

	// Scores are unsigned activations.
	always_comb
	begin
		bestIdx = '0;
		bestVal = scores[0];
		for (int i = 1; i < `CLASS_COUNT; i++)
		begin
			if (scores[i] > bestVal) // Strict, so the lower index keeps a tie.
			begin
				bestIdx = classIdx'(i);
				bestVal = scores[i];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			classOut <= '0;
			bestScore <= '0;
		end
		else
		begin
			classOut <= bestIdx;
			bestScore <= bestVal;
		end
	end

endmodule

// ==== hw/classifierPkg.sv ====
`include "classifier_cfg.svh"

package classifierPkg;

	typedef enum logic
	{
		hiddenKind,
		outputKind
	} layerKind;

	typedef logic [`FEATURE_COUNT-1:0][`ACT_WIDTH-1:0] featureVec;
	typedef logic [`HIDDEN_COUNT-1:0][`ACT_WIDTH-1:0] hiddenVec;
	typedef logic [`CLASS_COUNT-1:0][`ACT_WIDTH-1:0] scoreVec;
	typedef logic [$clog2(`CLASS_COUNT)-1:0] classIdx;

	// Index 0 is the leftmost weight of a row.
	typedef logic [0:`FEATURE_COUNT-1][7:0] weightRow;
	typedef logic [0:`HIDDEN_COUNT-1][7:0] outputRow;

	localparam weightRow hiddenWeights [`HIDDEN_COUNT] = '{
		{8'sd8, 8'sd32, 8'sd60, 8'sd28, -8'sd20, -8'sd8, 8'sd42, 8'sd40,
			-8'sd46, -8'sd4, 8'sd52, -8'sd30, 8'sd16, 8'sd20, 8'sd6},
		{-8'sd12, 8'sd18, 8'sd4, -8'sd36, 8'sd50, 8'sd22, -8'sd10, 8'sd14,
			8'sd30, -8'sd26, 8'sd8, 8'sd44, -8'sd18, 8'sd2, 8'sd24},
		{8'sd40, -8'sd6, -8'sd22, 8'sd12, 8'sd16, -8'sd48, 8'sd26, -8'sd2,
			8'sd10, 8'sd34, -8'sd14, 8'sd6, 8'sd38, -8'sd28, 8'sd0},
		{8'sd2, 8'sd14, -8'sd30, 8'sd56, -8'sd8, 8'sd10, 8'sd20, -8'sd40,
			8'sd18, 8'sd6, 8'sd28, -8'sd12, -8'sd4, 8'sd46, -8'sd16},
		{-8'sd24, -8'sd34, 8'sd12, 8'sd8, 8'sd36, 8'sd4, -8'sd18, 8'sd30,
			-8'sd6, 8'sd48, 8'sd2, 8'sd20, -8'sd38, 8'sd10, 8'sd26},
		{8'sd16, 8'sd26, 8'sd38, -8'sd14, -8'sd2, 8'sd30, 8'sd8, -8'sd20,
			8'sd44, -8'sd10, -8'sd32, 8'sd18, 8'sd12, 8'sd4, -8'sd42},
		{8'sd54, -8'sd16, 8'sd6, 8'sd20, 8'sd24, -8'sd12, -8'sd36, 8'sd10,
			8'sd2, 8'sd18, 8'sd40, -8'sd8, 8'sd28, -8'sd22, 8'sd14},
		{-8'sd4, 8'sd10, 8'sd28, 8'sd4, -8'sd44, 8'sd36, 8'sd12, 8'sd22,
			-8'sd28, 8'sd16, 8'sd6, 8'sd34, -8'sd10, 8'sd30, 8'sd8}
	};

	localparam logic signed [15:0] hiddenBias [`HIDDEN_COUNT] = '{
		-16'sd512, 16'sd256, -16'sd128, 16'sd640,
		16'sd0, -16'sd1024, 16'sd384, -16'sd256
	};

	localparam outputRow outputWeights [`CLASS_COUNT] = '{
		{8'sd12, -8'sd8, 8'sd20, 8'sd6, -8'sd14, 8'sd10, 8'sd4, 8'sd16},
		{-8'sd6, 8'sd18, 8'sd2, 8'sd14, 8'sd8, -8'sd12, 8'sd22, -8'sd4},
		{8'sd16, 8'sd4, -8'sd10, 8'sd20, 8'sd12, 8'sd6, -8'sd16, 8'sd8},
		{8'sd4, 8'sd10, 8'sd14, -8'sd6, 8'sd18, 8'sd2, 8'sd8, 8'sd12}
	};

	// Classes 0 and 1 share a bias, so a zero hidden layer gives a tie.
	localparam logic signed [15:0] outputBias [`CLASS_COUNT] = '{
		16'sd320, 16'sd320, -16'sd192, 16'sd128
	};

endpackage

// ==== hw/classifierTop.sv ====
`include "classifier_cfg.svh"

module classifierTop (
	input logic clk,
	input logic reset,
	input classifierPkg::featureVec features,
	output classifierPkg::scoreVec scores,
	output classifierPkg::classIdx classOut,
	output logic [`ACT_WIDTH-1:0] bestScore
);

	import classifierPkg::*;

	hiddenVec hiddenAct; // Three cycles behind features.

	denseLayer #(
		.kind(hiddenKind)
	) hiddenInst (
		.clk(clk),
		.reset(reset),
		.act(features),
		.result(hiddenAct)
	);

	// Scores land six cycles after features.
	denseLayer #(
		.kind(outputKind)
	) outputInst (
		.clk(clk),
		.reset(reset),
		.act(hiddenAct),
		.result(scores)
	);

	classSelect classSelectInst (
		.clk(clk),
		.reset(reset),
		.scores(scores),
		.classOut(classOut),
		.bestScore(bestScore)
	);

endmodule

// ==== hw/denseLayer.sv ====
`include "classifier_cfg.svh"

module denseLayer #(
	parameter classifierPkg::layerKind kind = classifierPkg::hiddenKind,
	localparam int inCount = (kind == classifierPkg::hiddenKind) ?
		`FEATURE_COUNT : `HIDDEN_COUNT,
	localparam int outCount = (kind == classifierPkg::hiddenKind) ?
		`HIDDEN_COUNT : `CLASS_COUNT
) (
	input logic clk,
	input logic reset,
	input logic [inCount-1:0][`ACT_WIDTH-1:0] act,
	output logic [outCount-1:0][`ACT_WIDTH-1:0] result
);

	import classifierPkg::*;

	// Output rows are shorter; the tail of the row stays zero.
	function automatic weightRow rowFor(int n);
		weightRow row;
		row = '0;
		if (kind == hiddenKind)
			row = hiddenWeights[n];
		else
			for (int i = 0; i < `HIDDEN_COUNT; i++)
				row[i] = outputWeights[n][i];
		return row;
	endfunction

	function automatic logic signed [15:0] biasFor(int n);
		if (kind == hiddenKind)
			return hiddenBias[n];
		else
			return outputBias[n];
	endfunction

	for (genvar n = 0; n < outCount; n++)
	begin : nodeGen
		neuronNode #(
			.inputCount(inCount),
			.weights(rowFor(n)),
			.bias(biasFor(n))
		) nodeInst (
			.clk(clk),
			.reset(reset),
			.act(act),
			.result(result[n])
		);
	end

endmodule

// ==== hw/neuronNode.sv ====
`include "classifier_cfg.svh"

module neuronNode #(
	parameter int inputCount = `FEATURE_COUNT,
	parameter classifierPkg::weightRow weights = '0,
	parameter logic signed [15:0] bias = '0
) (
	input logic clk,
	input logic reset,
	input logic [inputCount-1:0][`ACT_WIDTH-1:0] act,
	output logic [`ACT_WIDTH-1:0] result
);

	logic [inputCount-1:0][`ACT_WIDTH-1:0] actReg;
	logic signed [2*`ACT_WIDTH-1:0] product [inputCount];
	logic signed [`ACC_WIDTH-1:0] sum;
	logic signed [`ACC_WIDTH-1:0] acc;
	logic [`ACT_WIDTH-1:0] activation;

	// Input capture, first stage.
	always_ff @(posedge clk)
	begin
		if (reset)
			actReg <= '0;
		else
			actReg <= act;
	end

	for (genvar i = 0; i < inputCount; i++)
	begin : mulGen
		assign product[i] = $signed(actReg[i]) * $signed(weights[i]); // Signed 8x8.
	end

	// All operands signed, so each term is sign-extended to the accumulator.
	always_comb
	begin
		sum = bias;
		for (int i = 0; i < inputCount; i++)
			sum = sum + product[i];
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			acc <= '0;
		else
			acc <= sum;
	end

	// ReLU, saturate above bit 13, round half up on bit 5.
	always_comb
	begin
		if (acc[`ACC_WIDTH-1])
			activation = '0;
		else if (acc[`ACC_WIDTH-2:13] != '0)
			activation = 8'd127;
		else
			activation = acc[13:6] + {7'd0, acc[5]};
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			result <= '0;
		else
			result <= activation; // Third stage.
	end

endmodule

// ==== include/classifier_cfg.svh ====
`ifndef CLASSIFIER_CFG_SVH
`define CLASSIFIER_CFG_SVH

// Network shape.
`define FEATURE_COUNT 15
`define HIDDEN_COUNT 8
`define CLASS_COUNT 4

// Datapath widths.
`define ACT_WIDTH 8
`define ACC_WIDTH 23

// Features to class result, in cycles.
// Two dense layers of three cycles each, then the selector.
`define LATENCY 7

`endif

// ==== runSim.sh ====
#!/usr/bin/env bash
# Build and run the classifier testbench with Verilator.

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing -Wno-fatal \
	-f sources.f \
	--top-module classifierTb \
	--Mdir "$buildDir" \
	-o classifierTb
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
	echo "Verilator build failed with status $buildStatus"
	exit 1
fi

"./$buildDir/classifierTb" > "$logFile" 2>&1
runStatus=$?
cat "$logFile"
if [ $runStatus -ne 0 ]; then
	echo "Simulation exited with status $runStatus"
	exit 1
fi

if grep -q "SIMULATION FAILED" "$logFile"; then
	echo "Testbench reported failure, see $logFile"
	exit 1
fi

echo "Run complete, log in $logFile"
exit 0

// ==== sim/classifierTb.sv ====
`include "classifier_cfg.svh"

module classifierTb;

	import classifierPkg::*;

	localparam int vectorCount = 49;
	localparam int randomCount = 40;
	localparam int clkPeriod = 4;
	localparam int scoreLatency = `LATENCY - 1; // Selector adds the last cycle.
	localparam int watchdogTime = (vectorCount + `LATENCY + 10) * clkPeriod;

	logic clk;
	logic reset;
	featureVec features;
	scoreVec scores;
	classIdx classOut;
	logic [`ACT_WIDTH-1:0] bestScore;

	int seed = 32'h2418;
	int cycleCount = 0;
	int scoreErrors = 0;
	int classErrors = 0;
	int otherErrors = 0;

	// Expected results, oldest vector first.
	string nameQ [$];
	int issueQ [$];
	scoreVec scoreQ [$];
	classIdx classQ [$];
	logic [`ACT_WIDTH-1:0] bestQ [$];

	classifierTop classifierTop_inst (
		.clk(clk),
		.reset(reset),
		.features(features),
		.scores(scores),
		.classOut(classOut),
		.bestScore(bestScore)
	);

	initial clk = 1'b0;
	always #(clkPeriod / 2) clk = ~clk;

	always @(posedge clk)
		cycleCount <= cycleCount + 1;

	function automatic logic signed [`ACC_WIDTH-1:0] signExtend8(logic [7:0] v);
		return {{(`ACC_WIDTH - 8){v[7]}}, v};
	endfunction

	function automatic logic signed [`ACC_WIDTH-1:0] signExtend16(logic [15:0] v);
		return {{(`ACC_WIDTH - 16){v[15]}}, v};
	endfunction

	// Bias plus signed dot product of one hidden row with the features.
	function automatic logic signed [`ACC_WIDTH-1:0] hiddenAcc(featureVec f, int n);
		logic signed [`ACC_WIDTH-1:0] acc;
		acc = signExtend16(hiddenBias[n]);
		for (int i = 0; i < `FEATURE_COUNT; i++)
			acc = acc + signExtend8(f[i]) * signExtend8(hiddenWeights[n][i]);
		return acc;
	endfunction

	function automatic logic [`ACT_WIDTH-1:0] neuronRef(logic signed [`ACC_WIDTH-1:0] acc);
		logic signed [`ACC_WIDTH-1:0] scaled;
		if (acc < 23'sd0)
			return 8'd0;
		if (acc >= 23'sd8192) // Anything at or above bit 13.
			return 8'd127;
		scaled = (acc + 23'sd32) >>> 6; // Half rounds up.
		return scaled[7:0];
	endfunction

	function automatic void classifyRef(input featureVec f, output scoreVec s,
		output classIdx c, output logic [`ACT_WIDTH-1:0] b);
		hiddenVec h;
		logic signed [`ACC_WIDTH-1:0] acc;
		logic [`ACT_WIDTH-1:0] top;
		for (int n = 0; n < `HIDDEN_COUNT; n++)
			h[n] = neuronRef(hiddenAcc(f, n));
		for (int n = 0; n < `CLASS_COUNT; n++)
		begin
			acc = signExtend16(outputBias[n]);
			for (int i = 0; i < `HIDDEN_COUNT; i++)
				acc = acc + signExtend8(h[i]) * signExtend8(outputWeights[n][i]);
			s[n] = neuronRef(acc);
		end
		// Largest score, then the lowest index that holds it.
		top = 8'd0;
		for (int n = 0; n < `CLASS_COUNT; n++)
			if (s[n] > top)
				top = s[n];
		c = '0;
		for (int n = `CLASS_COUNT - 1; n >= 0; n--)
			if (s[n] == top)
				c = classIdx'(n);
		b = top;
	endfunction

	// True when some hidden neuron lands in the rounding range with bit 5 set.
	function automatic bit hasRoundUp(featureVec f);
		logic signed [`ACC_WIDTH-1:0] acc;
		for (int n = 0; n < `HIDDEN_COUNT; n++)
		begin
			acc = hiddenAcc(f, n);
			if (acc >= 23'sd0 && acc < 23'sd8192 && acc[5])
				return 1'b1;
		end
		return 1'b0;
	endfunction

	task automatic checkScores(string name, scoreVec expected, scoreVec actual);
		if (actual !== expected)
		begin
			scoreErrors++;
			$display("[ERROR] %s scores expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic checkClass(string name, classIdx expIdx, logic [`ACT_WIDTH-1:0] expBest,
		classIdx actIdx, logic [`ACT_WIDTH-1:0] actBest);
		if (actIdx !== expIdx || actBest !== expBest)
		begin
			classErrors++;
			$display("[ERROR] %s class expected %0d score %h actual %0d score %h",
				name, expIdx, expBest, actIdx, actBest);
		end
	endtask

	task automatic applyVector(string name, featureVec f);
		scoreVec s;
		classIdx c;
		logic [`ACT_WIDTH-1:0] b;
		classifyRef(f, s, c, b);
		@(posedge clk);
		features <= f;
		nameQ.push_back(name);
		issueQ.push_back(cycleCount + 1); // Edge number of this drive.
		scoreQ.push_back(s);
		classQ.push_back(c);
		bestQ.push_back(b);
	endtask

	// Outputs are stable at the falling edge.
	always @(negedge clk)
	begin
		for (int i = 0; i < issueQ.size(); i++)
			if (issueQ[i] + scoreLatency == cycleCount)
				checkScores(nameQ[i], scoreQ[i], scores);
		if (issueQ.size() != 0 && issueQ[0] + `LATENCY == cycleCount)
		begin
			checkClass(nameQ[0], classQ[0], bestQ[0], classOut, bestScore);
			void'(nameQ.pop_front());
			void'(issueQ.pop_front());
			void'(scoreQ.pop_front());
			void'(classQ.pop_front());
			void'(bestQ.pop_front());
		end
	end

	initial
	begin
		featureVec f;
		int found;
		int k;
		reset = 1'b1;
		features = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		checkScores("reset", '0, scores);
		checkClass("reset", '0, '0, classOut, bestScore);
		@(posedge clk);
		reset <= 1'b0; // Third reset edge.

		applyVector("zeroFeatures", '0);

		for (int i = 0; i < `FEATURE_COUNT; i++)
			f[i] = 8'd127;
		applyVector("saturateAll", f);
		for (int i = 0; i < `FEATURE_COUNT; i++)
			f[i] = ($signed(hiddenWeights[0][i]) > 0) ? 8'd127 : 8'd0;
		applyVector("saturatePositive", f);
		for (int i = 0; i < `FEATURE_COUNT; i++)
			f[i] = (i % 2 == 0) ? 8'd127 : 8'd90;
		applyVector("saturateMixed", f);

		// Single-feature vectors.
		found = 0;
		k = 0;
		while (found < 3 && k < 2000)
		begin
			f = '0;
			f[k % `FEATURE_COUNT] = 8'(1 + (k * 7) % 120);
			if (hasRoundUp(f))
			begin
				applyVector($sformatf("roundUp%0d", found), f);
				found++;
			end
			k++;
		end
		if (found < 3)
		begin
			otherErrors++;
			$display("Could not find three feature vectors that exercise rounding");
		end

		// All hidden accumulators negative, so classes 0 and 1 tie on bias.
		applyVector("tieMinimum", {`FEATURE_COUNT{8'h80}});
		applyVector("tieHalfNegative", {`FEATURE_COUNT{8'hc0}});

		for (int v = 0; v < randomCount; v++)
		begin
			for (int i = 0; i < `FEATURE_COUNT; i++)
				f[i] = 8'($random(seed));
			applyVector($sformatf("random%0d", v), f);
		end

		while (issueQ.size() != 0)
			@(negedge clk);

		$display("Errors: %0d score, %0d class, %0d other",
			scoreErrors, classErrors, otherErrors);
		if (scoreErrors + classErrors + otherErrors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	initial
	begin
		#(watchdogTime);
		$display("Timeout: results still pending after %0d time units", watchdogTime);
		$display("Errors: %0d score, %0d class, %0d other",
			scoreErrors, classErrors, otherErrors);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// ==== sources.f ====
+incdir+include
hw/classifierPkg.sv
hw/neuronNode.sv
hw/denseLayer.sv
hw/classSelect.sv
hw/classifierTop.sv
sim/classifierTb.sv
